// File: include/i2c_macros.svh
// i2c master parameters and register map

`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// i2c_clk cycles per quarter of an scl bit
`define I2C_DIV         4
// receive buffer depth, longest burst read
`define I2C_MAX_BURST   8

// wishbone word addresses
`define I2C_REG_CTRL    4'd0
`define I2C_REG_DEV     4'd1
`define I2C_REG_SUB     4'd2
`define I2C_REG_WDATA   4'd3
`define I2C_REG_STAT    4'd4
`define I2C_REG_RXBASE  4'd8

`endif

// File: src/i2c_pkg.sv
// i2c master shared types
`default_nettype none

package i2c_pkg;

	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} i2c_op_e;

	typedef enum logic [1:0] {
		SYM_START = 2'd0,
		SYM_STOP  = 2'd1,
		SYM_TX    = 2'd2,
		SYM_RX    = 2'd3
	} sym_kind_e;

	typedef enum logic [3:0] {
		IDLE, PTR_START, PTR_ADDR, PTR_SUB, WR_DATA, PTR_STOP,
		RD_START, RD_ADDR, RD_BYTE, FIN_STOP, DONE
	} ctrl_state_e;

	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [3:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed {
		i2c_op_e    op;
		logic [6:0] dev;
		logic [7:0] sub;
		logic [7:0] wdata;
		logic [2:0] len;    // bytes to read minus one
	} i2c_cmd_t;

	typedef struct packed {
		logic busy;
		logic done;
		logic nack;
	} i2c_stat_t;

	typedef struct packed {
		sym_kind_e  kind;
		logic [7:0] tx;
		logic       ack_out;  // level driven in the rx ack slot
	} sym_req_t;

	typedef struct packed {
		logic       done;
		logic [7:0] rx;
		logic       ack_in;   // 0 = slave acked
	} sym_rsp_t;

endpackage

`default_nettype wire

// File: src/i2c_rx_buffer.sv
// receive byte buffer
`default_nettype none

`include "i2c_macros.svh"

module i2c_rx_buffer (
	input  wire        i2c_clk,
	input  wire        i_rst_n,
	input  wire        i_we,
	input  wire [2:0]  i_widx,
	input  wire [7:0]  i_wbyte,
	input  wire [2:0]  i_ridx,
	output logic [7:0] o_rbyte
);

	logic [7:0] mem [`I2C_MAX_BURST];

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `I2C_MAX_BURST; i++) begin
				mem[i] <= 8'h00;
			end
		end else if (i_we) begin
			mem[i_widx] <= i_wbyte; // one byte per rx symbol
		end
	end

	// host side reads straight through
	assign o_rbyte = mem[i_ridx];

endmodule

`default_nettype wire

// File: src/i2c_symbol_engine.sv
// i2c bit timing and serializer
`default_nettype none

`include "i2c_macros.svh"

module i2c_symbol_engine import i2c_pkg::*; (
	input  wire           i2c_clk,
	input  wire           i_rst_n,
	input  wire           i_valid,
	input  wire sym_req_t i_sym,
	output sym_rsp_t      o_rsp,
	output logic          o_scl_oe,
	output logic          o_sda_oe,
	input  wire           i_sda
);

	localparam int DIV_W = $clog2(`I2C_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             qtick;     // last cycle of a quarter
	logic             busy;
	logic             done_q;
	sym_kind_e        kind_q;
	logic [1:0]       phase;
	logic [3:0]       bitn;      // 0..7 data, 8 ack slot
	logic [7:0]       shreg;
	logic             ack_q;
	logic             ack_in_q;
	logic             byte_sym;
	logic             last_q;
	logic             launch;
	logic             sda_next;

	assign launch   = i_valid && !busy;
	assign qtick    = busy && (div_cnt == DIV_W'(`I2C_DIV - 1));
	assign byte_sym = (kind_q == SYM_TX) || (kind_q == SYM_RX);
	assign last_q   = (phase == 2'd3) && (!byte_sym || (bitn == 4'd8));

	// sda for quarter 0 of the following bit
	always_comb begin
		if (kind_q == SYM_TX)
			sda_next = (bitn < 4'd7) ? ~shreg[7] : 1'b0; // release for slave ack
		else
			sda_next = (bitn == 4'd7) ? ~ack_q : 1'b0;
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy     <= 1'b0;
			done_q   <= 1'b0;
			div_cnt  <= '0;
			phase    <= 2'd0;
			bitn     <= 4'd0;
			o_scl_oe <= 1'b0;
			o_sda_oe <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (launch) begin
				busy    <= 1'b1;
				div_cnt <= '0;
				phase   <= 2'd0;
				bitn    <= 4'd0;
				case (i_sym.kind)
					SYM_START: begin
						o_scl_oe <= 1'b0;
						o_sda_oe <= 1'b0;
					end
					SYM_STOP: begin
						o_scl_oe <= 1'b1;
						o_sda_oe <= 1'b1;
					end
					SYM_TX: begin
						o_scl_oe <= 1'b1;
						o_sda_oe <= ~i_sym.tx[7]; // msb first
					end
					default: begin
						o_scl_oe <= 1'b1;
						o_sda_oe <= 1'b0;
					end
				endcase
			end else if (busy) begin
				div_cnt <= qtick ? '0 : div_cnt + 1'b1;
				if (qtick) begin
					phase <= phase + 2'd1;
					if (last_q) begin
						busy   <= 1'b0; // lines hold their last level
						done_q <= 1'b1;
					end else begin
						if (phase == 2'd3)
							bitn <= bitn + 4'd1;
						// levels for the quarter being entered
						case (kind_q)
							SYM_START: begin
								o_sda_oe <= (phase >= 2'd1); // falls with scl high
								o_scl_oe <= (phase == 2'd2);
							end
							SYM_STOP: begin
								o_scl_oe <= 1'b0;
								o_sda_oe <= (phase == 2'd0); // rises in quarter 2
							end
							default: begin
								o_scl_oe <= (phase >= 2'd2);
								if (phase == 2'd3)
									o_sda_oe <= sda_next;
							end
						endcase
					end
				end
			end
		end
	end

	// sample at the end of quarter 1, middle of scl high
	always_ff @(posedge i2c_clk) begin
		if (launch) begin
			kind_q <= i_sym.kind;
			shreg  <= i_sym.tx;
			ack_q  <= i_sym.ack_out;
		end else if (qtick && (phase == 2'd1) && byte_sym) begin
			if (bitn == 4'd8)
				ack_in_q <= i_sda;
			else
				shreg <= {shreg[6:0], i_sda};
		end
	end

	always_comb begin
		o_rsp.done   = done_q;
		o_rsp.rx     = shreg;
		o_rsp.ack_in = ack_in_q;
	end

endmodule

`default_nettype wire

// File: src/i2c_master_ctrl.sv
// i2c transaction sequencer
`default_nettype none

module i2c_master_ctrl import i2c_pkg::*; (
	input  wire            i2c_clk,
	input  wire            i_rst_n,
	input  wire            i_start,
	input  wire i2c_cmd_t  i_cmd,
	output logic           o_sym_valid,
	output sym_req_t       o_sym,
	input  wire sym_rsp_t  i_sym,
	output i2c_stat_t      o_stat,
	output logic           o_rx_we,
	output logic [2:0]     o_rx_idx,
	output logic [7:0]     o_rx_byte
);

	ctrl_state_e state;
	i2c_cmd_t    cmd_q;
	logic [2:0]  cnt;      // bytes received so far
	logic        done_q;
	logic        nack_q;
	logic        last_byte;
	logic        issuing;
	logic        tx_nack;

	assign last_byte = (cnt == cmd_q.len);
	assign issuing = (state != IDLE) && (state != DONE);
	assign o_sym_valid = issuing && !i_sym.done; // engine done retires the request
	assign tx_nack = i_sym.ack_in && (state inside {PTR_ADDR, PTR_SUB, WR_DATA, RD_ADDR});

	// symbol for the current step
	always_comb begin
		o_sym.kind    = SYM_TX;
		o_sym.tx      = 8'h00;
		o_sym.ack_out = 1'b0;
		case (state)
			PTR_START, RD_START: o_sym.kind = SYM_START;
			PTR_ADDR: o_sym.tx = {cmd_q.dev, 1'b0};
			PTR_SUB:  o_sym.tx = cmd_q.sub;
			WR_DATA:  o_sym.tx = cmd_q.wdata;
			RD_ADDR:  o_sym.tx = {cmd_q.dev, 1'b1};
			RD_BYTE: begin
				o_sym.kind    = SYM_RX;
				o_sym.ack_out = last_byte; // nack ends the burst
			end
			PTR_STOP, FIN_STOP: o_sym.kind = SYM_STOP;
			default: ;
		endcase
	end

	assign o_rx_we   = (state == RD_BYTE) && i_sym.done;
	assign o_rx_idx  = cnt;
	assign o_rx_byte = i_sym.rx;

	always_comb begin
		o_stat.busy = (state != IDLE);
		o_stat.done = done_q;
		o_stat.nack = nack_q;
	end

	// command snapshot, host may rewrite registers meanwhile
	always_ff @(posedge i2c_clk) begin
		if ((state == IDLE) && i_start)
			cmd_q <= i_cmd;
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state  <= IDLE;
			cnt    <= 3'd0;
			done_q <= 1'b0;
			nack_q <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_start) begin
						state  <= PTR_START;
						cnt    <= 3'd0;
						done_q <= 1'b0;
						nack_q <= 1'b0;
					end
				end
				DONE: begin
					state  <= IDLE;
					done_q <= 1'b1; // rises with busy falling
				end
				default: begin
					if (i_sym.done) begin
						if (tx_nack)
							nack_q <= 1'b1;
						case (state)
							PTR_START: state <= PTR_ADDR;
							PTR_ADDR:  state <= tx_nack ? FIN_STOP : PTR_SUB;
							PTR_SUB: begin
								if (tx_nack)
									state <= FIN_STOP;
								else
									state <= (cmd_q.op == OP_WRITE) ? WR_DATA : PTR_STOP;
							end
							WR_DATA:   state <= FIN_STOP;
							PTR_STOP:  state <= RD_START;
							RD_START:  state <= RD_ADDR;
							RD_ADDR:   state <= tx_nack ? FIN_STOP : RD_BYTE;
							RD_BYTE: begin
								if (last_byte)
									state <= FIN_STOP;
								else
									cnt <= cnt + 3'd1;
							end
							FIN_STOP:  state <= DONE;
							default:   state <= IDLE;
						endcase
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/i2c_wb_regs.sv
// wishbone register block
`default_nettype none

`include "i2c_macros.svh"

module i2c_wb_regs import i2c_pkg::*; (
	input  wire            i2c_clk,
	input  wire            i_rst_n,
	input  wire wb_req_t   i_wb,
	output logic           o_wb_ack,
	output logic [7:0]     o_wb_dat,
	output i2c_cmd_t       o_cmd,
	output logic           o_start,
	input  wire i2c_stat_t i_stat,
	output logic [2:0]     o_rx_idx,
	input  wire [7:0]      i_rx_byte
);

	logic [6:0] dev_q;
	logic [7:0] sub_q;
	logic [7:0] wdata_q;
	i2c_op_e    op_q;
	logic [2:0] len_q;
	logic       req;
	logic       wr_ctrl;
	logic [7:0] rd_mux;

	// the cycle carrying ack never starts a new transfer
	assign req = i_wb.cyc && i_wb.stb && !o_wb_ack;
	assign wr_ctrl = req && i_wb.we && (i_wb.adr == `I2C_REG_CTRL);
	assign o_rx_idx = i_wb.adr[2:0]; // window base is 8

	always_comb begin
		rd_mux = 8'h00;
		if (i_wb.adr >= `I2C_REG_RXBASE) begin
			rd_mux = i_rx_byte;
		end else begin
			case (i_wb.adr)
				`I2C_REG_CTRL:  rd_mux = {4'b0000, len_q, op_q};
				`I2C_REG_DEV:   rd_mux = {1'b0, dev_q};
				`I2C_REG_SUB:   rd_mux = sub_q;
				`I2C_REG_WDATA: rd_mux = wdata_q;
				`I2C_REG_STAT:  rd_mux = {5'b00000, i_stat.nack, i_stat.done, i_stat.busy};
				default:        rd_mux = 8'h00;
			endcase
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_wb_ack <= 1'b0;
			o_wb_dat <= 8'h00;
			o_start  <= 1'b0;
			dev_q    <= 7'h00;
			sub_q    <= 8'h00;
			wdata_q  <= 8'h00;
			op_q     <= OP_WRITE;
			len_q    <= 3'd0;
		end else begin
			o_wb_ack <= req;
			o_start  <= wr_ctrl && !i_stat.busy; // one pulse per accepted ctrl write
			if (req && !i_wb.we)
				o_wb_dat <= rd_mux;
			if (req && i_wb.we) begin
				case (i_wb.adr)
					`I2C_REG_DEV:   dev_q   <= i_wb.dat[6:0];
					`I2C_REG_SUB:   sub_q   <= i_wb.dat;
					`I2C_REG_WDATA: wdata_q <= i_wb.dat;
					`I2C_REG_CTRL: begin
						// ctrl layout: bit 0 op, bits 3:1 length minus one
						if (!i_stat.busy) begin
							op_q  <= i2c_op_e'(i_wb.dat[0]);
							len_q <= i_wb.dat[3:1];
						end
					end
					default: ; // status and buffer are read only
				endcase
			end
		end
	end

	always_comb begin
		o_cmd.op    = op_q;
		o_cmd.dev   = dev_q;
		o_cmd.sub   = sub_q;
		o_cmd.wdata = wdata_q;
		o_cmd.len   = len_q;
	end

endmodule

`default_nettype wire

// File: src/i2c_sensor_master.sv
// i2c sensor master top
`default_nettype none

module i2c_sensor_master import i2c_pkg::*; (
	input  wire          i2c_clk,
	input  wire          i_rst_n,
	input  wire wb_req_t i_wb,
	output wire          o_wb_ack,
	output wire [7:0]    o_wb_dat,
	output wire          o_scl_oe,  // 1 pulls scl low
	output wire          o_sda_oe,  // 1 pulls sda low
	input  wire          i_sda
);

	i2c_cmd_t  cmd;
	i2c_stat_t stat;
	sym_req_t  sym_req;
	sym_rsp_t  sym_rsp;
	wire       start;
	wire       sym_valid;
	wire       rx_we;
	wire [2:0] rx_widx;
	wire [7:0] rx_wbyte;
	wire [2:0] rx_ridx;
	wire [7:0] rx_rbyte;

	i2c_wb_regs u_regs (
		.i2c_clk  (i2c_clk),
		.i_rst_n  (i_rst_n),
		.i_wb     (i_wb),
		.o_wb_ack (o_wb_ack),
		.o_wb_dat (o_wb_dat),
		.o_cmd    (cmd),
		.o_start  (start),
		.i_stat   (stat),
		.o_rx_idx (rx_ridx),
		.i_rx_byte(rx_rbyte)
	);

	i2c_master_ctrl u_ctrl (
		.i2c_clk    (i2c_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (start),
		.i_cmd      (cmd),
		.o_sym_valid(sym_valid),
		.o_sym      (sym_req),
		.i_sym      (sym_rsp),
		.o_stat     (stat),
		.o_rx_we    (rx_we),
		.o_rx_idx   (rx_widx),
		.o_rx_byte  (rx_wbyte)
	);

	i2c_symbol_engine u_engine (
		.i2c_clk (i2c_clk),
		.i_rst_n (i_rst_n),
		.i_valid (sym_valid),
		.i_sym   (sym_req),
		.o_rsp   (sym_rsp),
		.o_scl_oe(o_scl_oe),
		.o_sda_oe(o_sda_oe),
		.i_sda   (i_sda)
	);

	i2c_rx_buffer u_rxbuf (
		.i2c_clk(i2c_clk),
		.i_rst_n(i_rst_n),
		.i_we   (rx_we),
		.i_widx (rx_widx),
		.i_wbyte(rx_wbyte),
		.i_ridx (rx_ridx),
		.o_rbyte(rx_rbyte)
	);

endmodule

`default_nettype wire

// File: dv/i2c_slave_model.sv
// behavioral i2c slave
`default_nettype none

module i2c_slave_model #(
	parameter logic [6:0] dev_addr = 7'h1D
) (
	input  wire  i_scl,
	input  wire  i_sda,
	output logic o_sda_oe  // 1 pulls sda low
);

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum {S_IDLE, S_ADDR, S_SUB, S_WDATA, S_READ} slave_state_e;

	slave_state_e state;
	logic [7:0]   mem [256];
	logic [7:0]   ptr;
	logic [7:0]   shreg;
	logic [7:0]   txb;       // byte being sent to the master
	int           bitcnt;
	logic         fresh;     // skip the scl fall that ends START
	logic         mack;
	logic         scl_q;
	logic         sda_q;
	int           start_cnt;
	int           stop_cnt;
	logic [7:0]   wlog [$];  // bytes written by the master
	logic         ack_log [$]; // master ack bits during reads
	integer       seed;

	initial begin
		seed = 53179;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'($random(seed));
		end
		state     = S_IDLE;
		o_sda_oe  = 1'b0;
		scl_q     = 1'b1;
		sda_q     = 1'b1;
		start_cnt = 0;
		stop_cnt  = 0;
		bitcnt    = 0;
		fresh     = 1'b0;
		ptr       = 8'h00;
	end

	always @(i_scl or i_sda) begin
		if (scl_q && i_scl && sda_q && !i_sda) begin
			start_cnt++; // sda fell with scl high
			state    = S_ADDR;
			bitcnt   = 0;
			fresh    = 1'b1;
			o_sda_oe = 1'b0;
		end else if (scl_q && i_scl && !sda_q && i_sda) begin
			stop_cnt++;
			state    = S_IDLE;
			o_sda_oe = 1'b0;
		end else if (!scl_q && i_scl && state != S_IDLE) begin
			if (bitcnt < 8)
				shreg = {shreg[6:0], i_sda};
			else if (state == S_READ) begin
				mack = i_sda;
				ack_log.push_back(i_sda);
			end
		end else if (scl_q && !i_scl && state != S_IDLE) begin
			if (fresh) begin
				fresh = 1'b0;
			end else if (bitcnt == 7) begin
				bitcnt   = 8;
				o_sda_oe = 1'b0; // read: release for the master ack
				case (state)
					S_ADDR: begin
						if (shreg[7:1] == dev_addr) begin
							wlog.push_back(shreg);
							o_sda_oe = 1'b1;
						end
					end
					S_SUB: begin
						ptr = shreg;
						wlog.push_back(shreg);
						o_sda_oe = 1'b1;
					end
					S_WDATA: begin
						mem[ptr] = shreg;
						ptr = ptr + 8'd1;
						wlog.push_back(shreg);
						o_sda_oe = 1'b1;
					end
					default: ;
				endcase
			end else if (bitcnt == 8) begin
				bitcnt   = 0;
				o_sda_oe = 1'b0;
				case (state)
					S_ADDR: begin
						if (shreg[7:1] != dev_addr)
							state = S_IDLE;
						else if (shreg[0]) begin
							state    = S_READ;
							txb      = mem[ptr];
							ptr      = ptr + 8'd1;
							o_sda_oe = !txb[7];
						end else
							state = S_SUB;
					end
					S_SUB: state = S_WDATA;
					S_READ: begin
						if (mack)
							state = S_IDLE; // nack ends the burst
						else begin
							txb      = mem[ptr];
							ptr      = ptr + 8'd1;
							o_sda_oe = !txb[7];
						end
					end
					default: ;
				endcase
			end else begin
				bitcnt++;
				if (state == S_READ)
					o_sda_oe = !txb[7 - bitcnt];
			end
		end
		scl_q = i_scl;
		sda_q = i_sda;
	end

endmodule

`default_nettype wire

// File: dv/tb_i2c_sensor_master.sv
// i2c sensor master testbench
`default_nettype none

`include "i2c_macros.svh"

module tb_i2c_sensor_master import i2c_pkg::*; ;

	timeunit 1ns;
	timeprecision 100ps;

	logic       i2c_clk = 1'b0;
	logic       i_rst_n;
	wb_req_t    wb;
	wire        wb_ack;
	wire [7:0]  wb_dat;
	wire        scl_oe;
	wire        sda_oe;
	wire        slave_sda_oe;
	wire        scl;
	wire        sda;
	integer     seed = 53179;
	longint     t_rise;
	int         starts_at_rise;
	bit         rise_seen = 1'b0;
	logic [7:0] rd;
	logic [7:0] sub;
	logic [7:0] snap;
	int         starts0;
	int         stops0;
	int         lens [3] = '{1, 3, 8};

	// wired-and with pull-ups
	assign scl = ~scl_oe;
	assign sda = ~(sda_oe | slave_sda_oe);

	always #50 i2c_clk = ~i2c_clk;

	i2c_sensor_master UUT (
		.i2c_clk (i2c_clk),
		.i_rst_n (i_rst_n),
		.i_wb    (wb),
		.o_wb_ack(wb_ack),
		.o_wb_dat(wb_dat),
		.o_scl_oe(scl_oe),
		.o_sda_oe(sda_oe),
		.i_sda   (sda)
	);

	i2c_slave_model #(.dev_addr(7'h1D)) slave (
		.i_scl   (scl),
		.i_sda   (sda),
		.o_sda_oe(slave_sda_oe)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else fail_run($sformatf("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	task automatic wb_cycle(input logic we, input logic [3:0] adr, input logic [7:0] dat,
		output logic [7:0] rdat);
		bit got;
		got  = 1'b0;
		rdat = 8'h00;
		@(negedge i2c_clk);
		wb = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		for (int n = 0; n < 16 && !got; n++) begin
			@(negedge i2c_clk);
			if (wb_ack) begin
				got  = 1'b1;
				rdat = wb_dat;
			end
		end
		wb = '0;
		assert (got) else fail_run("no wishbone ack within 16 cycles");
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [7:0] dat);
		logic [7:0] dummy;
		wb_cycle(1'b1, adr, dat, dummy);
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [7:0] dat);
		wb_cycle(1'b0, adr, 8'h00, dat);
	endtask

	// poll STAT until busy falls
	task automatic wait_idle(output logic [7:0] stat);
		bit idle;
		idle = 1'b0;
		@(negedge i2c_clk); // start pulse reaches the sequencer
		for (int n = 0; n < 4000 && !idle; n++) begin
			wb_read(`I2C_REG_STAT, stat);
			idle = !stat[0];
		end
		assert (idle) else fail_run("transaction still busy after 4000 status polls");
	endtask

	task automatic start_cmd(input logic op, input int len);
		starts0 = slave.start_cnt;
		stops0  = slave.stop_cnt;
		wb_write(`I2C_REG_CTRL, {4'b0000, 3'(len - 1), op});
	endtask

	task automatic check_burst(input logic [7:0] base, input int len);
		for (int i = 0; i < len; i++) begin
			wb_read(`I2C_REG_RXBASE + 4'(i), rd);
			check_val($sformatf("rx[%0d]", i), rd, slave.mem[base + 8'(i)]);
		end
		check_val("ack_log_size", 8'(slave.ack_log.size()), 8'(len));
		for (int i = 0; i < len; i++) begin
			check_val("master_ack", {7'b0, slave.ack_log[i]}, (i == len - 1) ? 8'h01 : 8'h00);
		end
		check_val("start_count", 8'(slave.start_cnt - starts0), 8'd2);
		check_val("stop_count", 8'(slave.stop_cnt - stops0), 8'd2);
	endtask

	// scl high time check skips the high level that holds a START
	always @(scl) begin
		if (scl === 1'b1) begin
			t_rise         = $time;
			starts_at_rise = slave.start_cnt;
			rise_seen      = 1'b1;
		end else if (rise_seen && slave.start_cnt == starts_at_rise) begin
			assert (($time - t_rise) == longint'(2 * `I2C_DIV * 100))
			else fail_run($sformatf("Mismatch scl_high_ns: got 0x%0h expected 0x%0h",
				$time - t_rise, 2 * `I2C_DIV * 100));
		end
	end

	initial begin
		wb      = '0;
		i_rst_n = 1'b0;
		repeat (8) @(negedge i2c_clk);
		i_rst_n = 1'b1;

		check_val("o_scl_oe", {7'b0, scl_oe}, 8'h00);
		check_val("o_sda_oe", {7'b0, sda_oe}, 8'h00);
		check_val("o_wb_ack", {7'b0, wb_ack}, 8'h00);
		wb_read(`I2C_REG_STAT, rd);
		check_val("STAT", rd, 8'h00);
		wb_write(`I2C_REG_DEV, 8'h1D);
		wb_write(`I2C_REG_SUB, 8'h5A);
		wb_write(`I2C_REG_WDATA, 8'hC3);
		wb_read(`I2C_REG_DEV, rd);
		check_val("DEV", rd, 8'h1D);
		wb_read(`I2C_REG_SUB, rd);
		check_val("SUB", rd, 8'h5A);
		wb_read(`I2C_REG_WDATA, rd);
		check_val("WDATA", rd, 8'hC3);

		// register write
		slave.wlog.delete();
		start_cmd(1'b0, 1);
		wait_idle(rd);
		check_val("STAT", rd, 8'h02);
		check_val("slave_mem", slave.mem[8'h5A], 8'hC3);
		check_val("wlog_size", 8'(slave.wlog.size()), 8'd3);
		check_val("wlog[0]", slave.wlog[0], {7'h1D, 1'b0});
		check_val("wlog[1]", slave.wlog[1], 8'h5A);
		check_val("wlog[2]", slave.wlog[2], 8'hC3);
		check_val("start_count", 8'(slave.start_cnt - starts0), 8'd1);
		check_val("stop_count", 8'(slave.stop_cnt - stops0), 8'd1);

		// burst reads
		foreach (lens[k]) begin
			sub = 8'($random(seed));
			wb_write(`I2C_REG_SUB, sub);
			slave.ack_log.delete();
			start_cmd(1'b1, lens[k]);
			wait_idle(rd);
			check_val("STAT", rd, 8'h02);
			check_burst(sub, lens[k]);
		end

		// absent device
		wb_write(`I2C_REG_DEV, 8'h2A);
		wb_write(`I2C_REG_SUB, 8'h5A);
		wb_write(`I2C_REG_WDATA, 8'h77);
		slave.wlog.delete();
		snap = slave.mem[8'h5A];
		start_cmd(1'b0, 1);
		wait_idle(rd);
		check_val("STAT", rd, 8'h06);
		check_val("slave_mem", slave.mem[8'h5A], snap);
		check_val("wlog_size", 8'(slave.wlog.size()), 8'd0);
		check_val("start_count", 8'(slave.start_cnt - starts0), 8'd1);
		check_val("stop_count", 8'(slave.stop_cnt - stops0), 8'd1);
		check_val("o_scl_oe", {7'b0, scl_oe}, 8'h00);
		check_val("o_sda_oe", {7'b0, sda_oe}, 8'h00);

		// ctrl write while busy is acked and dropped
		wb_write(`I2C_REG_DEV, 8'h1D);
		wb_write(`I2C_REG_SUB, 8'h10);
		slave.ack_log.delete();
		start_cmd(1'b1, 3);
		@(negedge i2c_clk);
		wb_write(`I2C_REG_CTRL, 8'h00);
		wait_idle(rd);
		check_val("STAT", rd, 8'h02);
		check_burst(8'h10, 3);
		repeat (200) @(negedge i2c_clk);
		check_val("start_count", 8'(slave.start_cnt - starts0), 8'd2);
		wb_read(`I2C_REG_STAT, rd);
		check_val("STAT", rd, 8'h02);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: i2c_sensor_master.f
+incdir+include
src/i2c_pkg.sv
src/i2c_rx_buffer.sv
src/i2c_symbol_engine.sv
src/i2c_master_ctrl.sv
src/i2c_wb_regs.sv
src/i2c_sensor_master.sv
dv/i2c_slave_model.sv
dv/tb_i2c_sensor_master.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= tb_i2c_sensor_master
FILELIST  ?= i2c_sensor_master.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
